/* list.f */
sdram_pkg.sv
sdram_sequencer.sv
sdram_phase_gen.sv
sdram_bus_gen.sv
sdram_port_strobes.sv
sdram_cmd_gen.sv
tb_sdram_cmd_gen.sv

/* run.sh */
#!/bin/bash
# Build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_sdram_cmd_gen -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

/* tb_sdram_cmd_gen.sv */
`timescale 1ns/10ps

module tb_sdram_cmd_gen;
    import sdram_pkg::*;

    localparam int SLOT_START    = 3;
    localparam int SLOT_STOP     = 10;
    localparam int SLOT_REFR     = 9;
    localparam int REFR_PER_LINE = 2;
    localparam int INIT_LINES    = 2;
    localparam int LINE_CLKS     = 16 * (SLOT_STOP - SLOT_START + 1);
    localparam int TIMEOUT       = 8 * LINE_CLKS + 200;   // Eight lines plus margin

    logic                      rst;       // Clock
    logic                      clk;       // Reset
    port_req_t [NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0]      valid;
    logic [NUM_PORTS-1:0]      fetch;
    logic                      ram_rdy_n;
    logic                      ram_ref;
    logic [SLOT_W-1:0]         ram_slot;
    logic                      sdram_ras_n;
    logic                      sdram_cas_n;
    logic                      sdram_we_n;
    logic [1:0]                sdram_ba;
    logic [ADDR_W-1:0]         sdram_addr;
    sdram_cmd_t                cmd_mon;

    // Bus log, filled by the monitor
    sdram_cmd_t        log_cmd[$];
    logic [1:0]        log_ba[$];
    logic [ADDR_W-1:0] log_addr[$];
    int                log_cyc[$];
    int                valid_cnt [NUM_PORTS];
    int                fetch_cnt [NUM_PORTS];
    int                fetch_first [NUM_PORTS];
    int                clk_cnt;
    int                errors;
    int                tests;
    int                rel_cnt;
    logic [SLOT_W-1:0] prev_slot;
    logic [31:0]       rng;

    sdram_cmd_gen #(
        .SLOT_START    (SLOT_START),
        .SLOT_STOP     (SLOT_STOP),
        .SLOT_REFR     (SLOT_REFR),
        .REFR_PER_LINE (REFR_PER_LINE),
        .INIT_LINES    (INIT_LINES)
    ) i_sdram_cmd_gen (
        .rst         (rst),
        .clk         (clk),
        .req         (req),
        .valid       (valid),
        .fetch       (fetch),
        .ram_rdy_n   (ram_rdy_n),
        .ram_ref     (ram_ref),
        .ram_slot    (ram_slot),
        .sdram_ras_n (sdram_ras_n),
        .sdram_cas_n (sdram_cas_n),
        .sdram_we_n  (sdram_we_n),
        .sdram_ba    (sdram_ba),
        .sdram_addr  (sdram_addr)
    );

    assign cmd_mon = sdram_cmd_t'({sdram_ras_n, sdram_cas_n, sdram_we_n});

    initial begin
        rst = 1'b0;
        forever #10 rst = ~rst;
    end

    // Run limit
    always @(posedge rst) begin
        clk_cnt <= clk_cnt + 1;
        if (clk_cnt > TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d clocks", TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    end

    assert property (@(posedge rst) disable iff (clk) (cmd_mon == CMD_REF) |-> ram_ref)
        else begin
            errors++;
            $display("REF command issued outside the refresh window");
        end

    assert property (@(posedge rst) disable iff (clk)
        (cmd_mon inside {CMD_ACT, CMD_RD, CMD_WR}) |-> !ram_rdy_n)
        else begin
            errors++;
            $display("Port access command issued before init finished");
        end

    // ========================================
    // Bus monitor
    // ========================================
    always @(negedge rst) begin
        if (clk) begin
            prev_slot = SLOT_W'(SLOT_START);
        end else begin
            if (cmd_mon != CMD_NOP) begin
                log_cmd.push_back(cmd_mon);
                log_ba.push_back(sdram_ba);
                log_addr.push_back(sdram_addr);
                log_cyc.push_back(clk_cnt);
            end
            for (int k = 0; k < NUM_PORTS; k++) begin
                valid_cnt[k] += int'(valid[k]);
                if (fetch[k]) begin
                    if (fetch_cnt[k] == 0) begin
                        fetch_first[k] = clk_cnt;
                    end
                    fetch_cnt[k]++;
                end
            end
            if (ram_slot != prev_slot) begin
                // Step by one or wrap at line end
                assert ((ram_slot == prev_slot + 1'b1) ||
                        (prev_slot == SLOT_W'(SLOT_STOP) && ram_slot == SLOT_W'(SLOT_START)))
                    else begin
                        errors++;
                        $display("Error: ram_slot stepped from %h to %h", prev_slot, ram_slot);
                    end
            end
            assert (ram_slot >= SLOT_W'(SLOT_START) && ram_slot <= SLOT_W'(SLOT_STOP))
                else begin
                    errors++;
                    $display("Error: ram_slot out of range %h", ram_slot);
                end
            assert (!(cmd_mon == CMD_ACT && ram_ref))
                else begin
                    errors++;
                    $display("ACT issued inside the refresh window");
                end
            prev_slot = ram_slot;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic clear_log();
        log_cmd.delete();
        log_ba.delete();
        log_addr.delete();
        log_cyc.delete();
        for (int k = 0; k < NUM_PORTS; k++) begin
            valid_cnt[k]   = 0;
            fetch_cnt[k]   = 0;
            fetch_first[k] = 0;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("Test %s: %0d errors", name, errors - err_before);
    endtask

    // Returns 2 ns after the edge that opens a slot in [lo, hi]
    task automatic wait_slot_start(input int lo, input int hi);
        logic [SLOT_W-1:0] last;
        logic              found;
        found = 1'b0;
        last  = ram_slot;
        while (!found) begin
            @(posedge rst);
            #2;
            if (ram_slot != last && ram_slot >= SLOT_W'(lo) && ram_slot <= SLOT_W'(hi)) begin
                found = 1'b1;
            end
            last = ram_slot;
        end
    endtask

    // mode 0 idle, 1 read, 2 write
    task automatic check_port(input int k, input int mode, input logic [31:0] a);
        int                idx[$];
        int                exp_n;
        logic [ADDR_W-1:0] row;
        logic [ADDR_W-1:0] col;
        row   = a[22:10];
        col   = {4'b0000, a[9:1]};
        exp_n = (mode == 1) ? 3 : (mode == 2) ? 2 : 0;
        foreach (log_cmd[i]) begin
            if (log_ba[i] == 2'(k) && log_cmd[i] inside {CMD_ACT, CMD_RD, CMD_WR}) begin
                idx.push_back(i);
            end
        end
        check_val($sformatf("port %0d command count", k), idx.size(), exp_n);
        if (idx.size() == exp_n && exp_n > 0) begin
            check_val("act cmd", log_cmd[idx[0]], CMD_ACT);
            check_val("act row", log_addr[idx[0]], row);
            if (mode == 1) begin
                check_val("rd cmd", log_cmd[idx[1]], CMD_RD);
                check_val("rd addr", log_addr[idx[1]], col);
                check_val("rd ap cmd", log_cmd[idx[2]], CMD_RD);
                check_val("rd ap addr", log_addr[idx[2]], col | 13'h400);
                check_val("rd spacing", log_cyc[idx[2]] - log_cyc[idx[1]], 2);
            end else begin
                check_val("wr cmd", log_cmd[idx[1]], CMD_WR);
                check_val("wr addr", log_addr[idx[1]], col | 13'h400);
                assert (fetch_cnt[k] > 0 && fetch_first[k] < log_cyc[idx[1]]) else begin
                    errors++;
                    $display("Fetch on port %0d did not come before its WR", k);
                end
            end
        end
        check_val($sformatf("valid[%0d] cycles", k), valid_cnt[k], (mode == 1) ? 4 : 0);
        check_val($sformatf("fetch[%0d] cycles", k), fetch_cnt[k], (mode == 2) ? 2 : 0);
    endtask

    // One port, request held for its own access only
    task automatic run_single(input int k, input logic rd, input logic wr,
                              input logic [31:0] a);
        wait_slot_start(SLOT_START, SLOT_START + 3);
        clear_log();
        if (k > 0) begin
            repeat (4 * k) @(posedge rst);
            #2;
        end
        req[k].rden = rd;
        req[k].wren = wr;
        req[k].addr = a;
        repeat (4) @(posedge rst);
        #2;
        req = '0;
        repeat (28 - 4 * k) @(posedge rst);  // Let valid/fetch drain
        #2;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int                err0;
        int                n;
        int                last_ba;
        int                mode [NUM_PORTS];
        logic [31:0]       addr [NUM_PORTS];
        clk     = 1'b1;
        req     = '0;
        rng     = 32'h47a794f2;
        errors  = 0;
        tests   = 0;
        clk_cnt = 0;
        clear_log();

        // Reset state
        err0 = errors;
        repeat (3) @(posedge rst);
        check_val("command", cmd_mon, CMD_NOP);
        check_val("ram_rdy_n", ram_rdy_n, 1);
        check_val("ram_ref", ram_ref, 0);
        check_val("valid", valid, 0);
        check_val("fetch", fetch, 0);
        check_val("sdram_addr", sdram_addr, 0);
        #2;
        clk     = 1'b0;
        rel_cnt = clk_cnt;
        end_test("reset", err0);

        // Init sequence, every port keeps requesting until ready
        err0 = errors;
        for (int k = 0; k < NUM_PORTS; k++) begin
            rng         = xorshift32(rng);
            req[k].rden = (k % 2 == 0);
            req[k].wren = 1'b1;
            req[k].addr = rng;
        end
        while (ram_rdy_n) begin
            @(posedge rst);
            #2;
        end
        req = '0;                       // Cleared before port 0 samples
        n = clk_cnt - rel_cnt;
        assert (n >= INIT_LINES * LINE_CLKS - 4 && n <= INIT_LINES * LINE_CLKS + 4) else begin
            errors++;
            $display("Error: ram_rdy_n fell after %h clocks, expected about %h",
                     n, INIT_LINES * LINE_CLKS);
        end
        check_val("init command count", log_cmd.size(), 4);
        if (log_cmd.size() == 4) begin
            check_val("init cmd 0", log_cmd[0], CMD_PRE);
            check_val("init pre addr", log_addr[0] & 13'h400, 13'h400);
            check_val("init cmd 1", log_cmd[1], CMD_REF);
            check_val("init cmd 2", log_cmd[2], CMD_REF);
            check_val("init cmd 3", log_cmd[3], CMD_LMR);
            check_val("init lmr addr", log_addr[3], 13'h221);
        end
        for (int k = 0; k < NUM_PORTS; k++) begin
            check_val($sformatf("valid[%0d] cycles in init", k), valid_cnt[k], 0);
            check_val($sformatf("fetch[%0d] cycles in init", k), fetch_cnt[k], 0);
        end
        end_test("init", err0);

        // Requests held through the refresh window
        err0 = errors;
        wait_slot_start(SLOT_STOP, SLOT_STOP);
        clear_log();
        for (int k = 0; k < NUM_PORTS; k++) begin
            req[k].rden = 1'b1;
        end
        repeat (8) @(posedge rst);
        #2;
        check_val("ram_ref in window", ram_ref, 1);
        repeat (8) @(posedge rst);
        #2;
        req = '0;
        check_val("ram_ref after window", ram_ref, 0);
        check_val("ram_slot after wrap", ram_slot, SLOT_START);
        n = 0;
        foreach (log_cmd[i]) begin
            n += (log_cmd[i] == CMD_REF) ? 1 : 0;
            check_val("command in window", log_cmd[i] == CMD_ACT, 0);
        end
        check_val("REF count in window", n, REFR_PER_LINE);
        end_test("slots_refresh", err0);

        // Single reads
        err0 = errors;
        for (int k = 0; k < NUM_PORTS; k++) begin
            rng = xorshift32(rng);
            run_single(k, 1'b1, 1'b0, rng);
            check_port(k, 1, rng);
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (j != k) begin
                    check_port(j, 0, 0);
                end
            end
        end
        end_test("read", err0);

        // Write, then read beats write
        err0 = errors;
        rng = xorshift32(rng);
        run_single(1, 1'b0, 1'b1, rng);
        check_port(1, 2, rng);
        rng = xorshift32(rng);
        run_single(3, 1'b1, 1'b1, rng);
        check_port(3, 1, rng);
        end_test("write_priority", err0);

        // All ports in one slot, random mix
        err0 = errors;
        for (int r = 0; r < 2; r++) begin
            wait_slot_start(SLOT_START, SLOT_START + 3);
            clear_log();
            for (int k = 0; k < NUM_PORTS; k++) begin
                rng     = xorshift32(rng);
                addr[k] = rng;
                rng     = xorshift32(rng);
                mode[k] = int'(rng[1:0]);
                req[k].rden = (mode[k] == 1) || (mode[k] == 3);
                req[k].wren = (mode[k] >= 2);
                req[k].addr = addr[k];
            end
            repeat (16) @(posedge rst);
            #2;
            req = '0;
            repeat (16) @(posedge rst);
            #2;
            for (int k = 0; k < NUM_PORTS; k++) begin
                check_port(k, (mode[k] == 3) ? 1 : mode[k], addr[k]);
            end
            last_ba = -1;
            foreach (log_cmd[i]) begin
                if (log_cmd[i] == CMD_ACT) begin
                    check_val("act order", int'(log_ba[i]) > last_ba, 1);
                    last_ba = int'(log_ba[i]);
                end
            end
        end
        end_test("back_to_back", err0);

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sdram_cmd_gen.sv */
`timescale 1ns/10ps

module sdram_cmd_gen
    import sdram_pkg::*;
#(
    parameter int SLOT_START    = 3,
    parameter int SLOT_STOP     = 288,
    parameter int SLOT_REFR     = 284,
    parameter int REFR_PER_LINE = 9,
    parameter int INIT_LINES    = 4
) (
    input  logic                      rst,        // Clock
    input  logic                      clk,        // Async reset, active high
    input  port_req_t [NUM_PORTS-1:0] req,
    output logic [NUM_PORTS-1:0]      valid,
    output logic [NUM_PORTS-1:0]      fetch,
    output logic                      ram_rdy_n,  // Low once init is over
    output logic                      ram_ref,    // Refresh window
    output logic [SLOT_W-1:0]         ram_slot,
    output logic                      sdram_ras_n,
    output logic                      sdram_cas_n,
    output logic                      sdram_we_n,
    output logic [1:0]                sdram_ba,
    output logic [ADDR_W-1:0]         sdram_addr
);

    seq_state_t seq;
    phase_t     ph;

    sdram_sequencer #(
        .SLOT_START    (SLOT_START),
        .SLOT_STOP     (SLOT_STOP),
        .SLOT_REFR     (SLOT_REFR),
        .REFR_PER_LINE (REFR_PER_LINE),
        .INIT_LINES    (INIT_LINES)
    ) i_sequencer (
        .rst (rst),
        .clk (clk),
        .seq (seq)
    );

    sdram_phase_gen i_phase_gen (
        .rst (rst),
        .clk (clk),
        .seq (seq),
        .req (req),
        .ph  (ph)
    );

    sdram_bus_gen i_bus_gen (
        .rst         (rst),
        .clk         (clk),
        .seq         (seq),
        .ph          (ph),
        .req         (req),
        .sdram_ras_n (sdram_ras_n),
        .sdram_cas_n (sdram_cas_n),
        .sdram_we_n  (sdram_we_n),
        .sdram_ba    (sdram_ba),
        .sdram_addr  (sdram_addr)
    );

    sdram_port_strobes i_port_strobes (
        .rst   (rst),
        .clk   (clk),
        .seq   (seq),
        .ph    (ph),
        .valid (valid),
        .fetch (fetch)
    );

    assign ram_rdy_n = ~seq.init_done;
    assign ram_ref   = seq.refr_ena;
    assign ram_slot  = seq.slot;

endmodule

/* sdram_port_strobes.sv */
`timescale 1ns/10ps

module sdram_port_strobes
    import sdram_pkg::*;
(
    input  logic                 rst,    // Clock
    input  logic                 clk,    // Async reset, active high
    input  seq_state_t           seq,
    input  phase_t               ph,
    output logic [NUM_PORTS-1:0] valid,  // Read data valid
    output logic [NUM_PORTS-1:0] fetch   // Write data fetch
);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            valid <= '0;
            fetch <= '0;
        end else begin
            if (seq.cyc[3]) begin
                // CAS 2 data lands during access k+2
                for (int k = 0; k < NUM_PORTS; k++) begin
                    valid[k] <= ph.rd_act[k] & seq.acc[(k + 1) % NUM_PORTS];
                end
                fetch <= ph.wr_act & seq.acc;   // Ahead of the WR
            end else if (seq.cyc[1]) begin
                fetch <= '0;
            end
        end
    end

endmodule

/* sdram_bus_gen.sv */
`timescale 1ns/10ps

module sdram_bus_gen
    import sdram_pkg::*;
(
    input  logic                      rst,    // Clock
    input  logic                      clk,    // Async reset, active high
    input  seq_state_t                seq,
    input  phase_t                    ph,
    input  port_req_t [NUM_PORTS-1:0] req,
    output logic                      sdram_ras_n,
    output logic                      sdram_cas_n,
    output logic                      sdram_we_n,
    output logic [1:0]                sdram_ba,
    output logic [ADDR_W-1:0]         sdram_addr
);

    localparam int WADDR_W = ROW_W + COL_W;   // Word address bits in use

    logic [WADDR_W-1:0] addr_sel;   // Port mux output
    logic [WADDR_W-1:0] addr_mux;   // Word address of current access
    logic [COL_W-1:0]   col_q;      // Column for next access's RD/WR
    sdram_addr_u        row_word;
    sdram_addr_u        col_word;
    sdram_addr_u        ap_word;    // Column with auto-precharge
    sdram_addr_u        pre_word;   // Precharge all banks
    sdram_addr_u        addr_nxt;
    logic [1:0]         ba_nxt;
    sdram_cmd_t         cmd_nxt;
    sdram_cmd_t         cmd_q;

    // ======================================
    // Port address mux
    // ======================================
    always_comb begin
        addr_sel = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (seq.acc[k] && (req[k].rden || req[k].wren)) begin
                addr_sel = addr_sel | req[k].addr[WADDR_W:1];  // 16-bit words
            end
        end
    end

    always_ff @(posedge rst) begin
        if (seq.cyc[0]) begin
            addr_mux <= addr_sel;
        end
        if (seq.cyc[3]) begin
            col_q <= addr_mux[COL_W-1:0];   // Held while next port loads
        end
    end

    always_comb begin
        row_word.row = addr_mux[WADDR_W-1:COL_W];
        col_word            = '0;
        col_word.col.column = col_q;
        ap_word        = col_word;
        ap_word.col.ap = 1'b1;
        pre_word        = '0;
        pre_word.col.ap = 1'b1;
    end

    // ======================================
    // Command, bank and address select
    // ======================================
    always_comb begin
        cmd_nxt  = CMD_NOP;
        addr_nxt = '0;
        ba_nxt   = 2'd0;
        if (seq.cyc[0] && ph.rd) begin
            cmd_nxt  = CMD_RD;          // First BL2 read
            addr_nxt = col_word;
            ba_nxt   = seq.ba_rw;
        end else if (seq.cyc[1]) begin
            if (ph.act) begin
                cmd_nxt  = CMD_ACT;
                addr_nxt = row_word;
                ba_nxt   = seq.ba_act;
            end else if (ph.pre) begin
                cmd_nxt  = CMD_PRE;
                addr_nxt = pre_word;
            end else if (ph.refr) begin
                cmd_nxt = CMD_REF;
            end else if (ph.lmr) begin
                cmd_nxt  = CMD_LMR;
                addr_nxt = MODE_WORD;
            end
        end else if (seq.cyc[2] && ph.rd) begin
            cmd_nxt  = CMD_RD;          // Second read closes the row
            addr_nxt = ap_word;
            ba_nxt   = seq.ba_rw;
        end else if (seq.cyc[3] && ph.wr) begin
            cmd_nxt  = CMD_WR;
            addr_nxt = ap_word;
            ba_nxt   = seq.ba_rw;
        end
    end

    // Output registers
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cmd_q      <= CMD_NOP;
            sdram_ba   <= 2'd0;
            sdram_addr <= '0;
        end else begin
            cmd_q      <= cmd_nxt;
            sdram_ba   <= ba_nxt;
            sdram_addr <= addr_nxt;
        end
    end

    assign {sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;

endmodule

/* sdram_phase_gen.sv */
`timescale 1ns/10ps

module sdram_phase_gen
    import sdram_pkg::*;
(
    input  logic                      rst,    // Clock
    input  logic                      clk,    // Async reset, active high
    input  seq_state_t                seq,
    input  port_req_t [NUM_PORTS-1:0] req,
    output phase_t                    ph
);

    logic [NUM_PORTS-1:0] rd_req;   // Qualified read per port
    logic [NUM_PORTS-1:0] wr_req;   // Qualified write per port
    logic                 init_run; // Last init line, window open

    // Requests count only after init and outside refresh
    always_comb begin
        for (int k = 0; k < NUM_PORTS; k++) begin
            rd_req[k] = req[k].rden & ~seq.refr_ena & seq.init_done;
            wr_req[k] = req[k].wren & ~req[k].rden      // Read wins
                      & ~seq.refr_ena & seq.init_done;
        end
    end

    assign init_run = seq.init_last & seq.refr_ena;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            ph <= '0;
        end else begin
            // ======================================
            // Per-port access latches
            // ======================================
            if (seq.cyc[0]) begin
                for (int k = 0; k < NUM_PORTS; k++) begin
                    if (seq.acc[k]) begin
                        ph.rd_act[k] <= rd_req[k];   // Sample on own access
                        ph.wr_act[k] <= wr_req[k];
                    end else if (seq.acc[(k + 2) % NUM_PORTS]) begin
                        // Access finished two accesses later
                        ph.rd_act[k] <= 1'b0;
                        ph.wr_act[k] <= 1'b0;
                    end
                end
            end

            // Activate for the port whose access starts now
            if (seq.cyc[0] && seq.init_done) begin
                ph.act <= |(seq.acc & (rd_req | wr_req));
            end

            // Read/write run in the following access
            if (seq.cyc[3] && seq.init_done) begin
                ph.rd <= |(seq.acc & ph.rd_act);
                ph.wr <= |(seq.acc & ph.wr_act);
            end

            // ======================================
            // Init steps, one per access
            // ======================================
            if (seq.cyc[3]) begin
                if (init_run) begin
                    if (!ph.ini[4]) begin
                        ph.ini <= {ph.ini[3:0], ~|ph.ini};  // Start or shift
                    end
                end else begin
                    ph.ini <= 5'b00000;
                end
            end

            ph.pre  <= ph.ini[0];                 // Precharge all
            ph.refr <= (seq.refr_ena & seq.init_done & seq.refr_ctr[0])  // Normal
                     | ph.ini[1] | ph.ini[2];                            // Init
            ph.lmr  <= ph.ini[3];                 // Mode register
        end
    end

endmodule

/* sdram_sequencer.sv */
`timescale 1ns/10ps

module sdram_sequencer
    import sdram_pkg::*;
#(
    parameter int SLOT_START    = 3,
    parameter int SLOT_STOP     = 288,
    parameter int SLOT_REFR     = 284,
    parameter int REFR_PER_LINE = 9,     // Up to 15
    parameter int INIT_LINES    = 4      // 1 to 8
) (
    input  logic       rst,    // Clock
    input  logic       clk,    // Async reset, active high
    output seq_state_t seq
);

    logic [3:0]        cyc;
    logic [3:0]        acc;
    logic [1:0]        ba_act;
    logic [1:0]        ba_rw;
    logic [SLOT_W-1:0] slot;
    logic              line_end;   // Registered stop compare
    logic [3:0]        init_ctr;   // Done when bit 3 sets
    logic              refr_ena;
    logic [4:0]        refr_ctr;
    logic              refr_beg;   // Window start compare
    logic              refr_end;   // Window length reached

    // ======================================
    // Rings, counters, refresh window
    // ======================================
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cyc      <= 4'b0001;
            acc      <= 4'b0001;
            ba_act   <= 2'd0;
            ba_rw    <= 2'd3;        // One behind the act bank
            slot     <= SLOT_W'(SLOT_START);
            line_end <= 1'b0;
            init_ctr <= 4'(8 - INIT_LINES);
            refr_ena <= 1'b0;
            refr_ctr <= 5'd0;
            refr_beg <= 1'b0;
            refr_end <= 1'b0;
        end else begin
            cyc <= {cyc[2:0], cyc[3]};  // 4 clocks per access

            if (cyc[3]) begin
                if (line_end) begin
                    // Scan-line wrap
                    acc    <= 4'b0001;
                    ba_act <= 2'd0;
                    ba_rw  <= 2'd3;
                    slot   <= SLOT_W'(SLOT_START);
                    if (!init_ctr[3]) begin
                        init_ctr <= init_ctr + 4'd1;
                    end
                end else begin
                    acc    <= {acc[2:0], acc[3]};
                    ba_act <= ba_act + 2'd1;
                    ba_rw  <= ba_rw + 2'd1;
                    if (acc[3]) begin
                        slot <= slot + 1'b1;    // Next slot after port 3
                    end
                end

                // Count accesses inside the window
                refr_ctr <= refr_ena ? refr_ctr + 5'd1 : 5'd0;
                if (refr_beg) begin
                    refr_ena <= 1'b1;
                end else if (refr_end) begin
                    refr_ena <= 1'b0;
                end
            end

            line_end <= (slot == SLOT_W'(SLOT_STOP)) && acc[ACC_STOP];
            refr_beg <= (slot == SLOT_W'(SLOT_REFR)) && acc[ACC_REFR];
            refr_end <= (refr_ctr == 5'(2 * REFR_PER_LINE));  // Two accesses per REF
        end
    end

    always_comb begin
        seq.cyc       = cyc;
        seq.acc       = acc;
        seq.ba_act    = ba_act;
        seq.ba_rw     = ba_rw;
        seq.slot      = slot;
        seq.init_done = init_ctr[3];
        seq.init_last = (init_ctr == 4'd7);
        seq.refr_ena  = refr_ena;
        seq.refr_ctr  = refr_ctr;
        seq.line_end  = line_end;
    end

endmodule

/* sdram_pkg.sv */
package sdram_pkg;

    // ======================================
    // Geometry and schedule constants
    // ======================================
    localparam int NUM_PORTS   = 4;     // One port per SDRAM bank
    localparam int ADDR_W      = 13;    // SDRAM address lines
    localparam int COL_W       = 9;     // 512 words per row
    localparam int ROW_W       = 13;    // 8192 rows
    localparam int PORT_ADDR_W = 32;    // Byte address from each port
    localparam int SLOT_W      = 9;     // Slot counter width

    localparam int ACC_REFR    = 2;     // Access that opens the refresh window
    localparam int ACC_STOP    = 3;     // Last access of a scan-line

    // WB single, normal op, CAS 2, sequential, BL2
    localparam logic [ADDR_W-1:0] MODE_WORD = 13'h221;

    // {RAS_n, CAS_n, WE_n}
    typedef enum logic [2:0] {
        CMD_LMR = 3'b000,
        CMD_REF = 3'b001,
        CMD_PRE = 3'b010,
        CMD_ACT = 3'b011,
        CMD_WR  = 3'b100,
        CMD_RD  = 3'b101,
        CMD_BST = 3'b110,
        CMD_NOP = 3'b111
    } sdram_cmd_t;

    // ======================================
    // Structs
    // ======================================
    typedef struct packed {
        logic                   rden;   // Read request level
        logic                   wren;   // Write request level
        logic [PORT_ADDR_W-1:0] addr;   // Byte address
    } port_req_t;

    typedef struct packed {
        logic [3:0]        cyc;        // Cycle in access, one-hot
        logic [3:0]        acc;        // Access in slot, one-hot
        logic [1:0]        ba_act;     // Bank being activated
        logic [1:0]        ba_rw;      // Bank one access behind
        logic [SLOT_W-1:0] slot;
        logic              init_done;
        logic              init_last;  // Final init scan-line
        logic              refr_ena;   // Refresh window open
        logic [4:0]        refr_ctr;   // Accesses spent in window
        logic              line_end;
    } seq_state_t;

    typedef struct packed {
        logic [NUM_PORTS-1:0] rd_act;  // Read in flight per port
        logic [NUM_PORTS-1:0] wr_act;  // Write in flight per port
        logic                 act;
        logic                 rd;
        logic                 wr;
        logic                 refr;
        logic                 pre;
        logic                 lmr;
        logic [4:0]           ini;     // PRE, REF, REF, LMR, finished
    } phase_t;

    // ======================================
    // Address word views
    // ======================================
    typedef struct packed {
        logic [1:0]       rsv_hi;
        logic             ap;          // A10, auto-precharge / all banks
        logic             rsv_lo;
        logic [COL_W-1:0] column;
    } col_fields_t;

    typedef struct packed {
        logic [2:0] rsv;
        logic       wb;    // Write burst mode
        logic [1:0] op;    // Operating mode
        logic [2:0] cas;   // CAS latency
        logic       bt;    // Burst type
        logic [2:0] bl;    // Burst length
    } mode_fields_t;

    typedef union packed {
        logic [ROW_W-1:0] row;
        col_fields_t      col;
        mode_fields_t     mode;
    } sdram_addr_u;

endpackage
